// File: design/apb_arbiter.sv
//##########################################################################
// Two-host APB arbiter with round-robin priority. A granted host keeps the
// shared bus for a whole transfer, until the slave returns pready. The
// forward path is combinational; only the grant state is registered.
//##########################################################################

module apb_arbiter (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  regsub_pkg::apb_req_t req0_i,
    input  regsub_pkg::apb_req_t req1_i,
    output regsub_pkg::apb_rsp_t rsp0_o,
    output regsub_pkg::apb_rsp_t rsp1_o,

    output regsub_pkg::apb_req_t bus_req_o,
    input  regsub_pkg::apb_rsp_t bus_rsp_i
);

    logic busy;
    logic owner;
    logic last_owner;
    logic next_owner;

    regsub_pkg::apb_req_t owner_req;

    // Pick the host that was not served last when both ask
    always_comb begin
        if (req0_i.psel && req1_i.psel) begin
            next_owner = ~last_owner;
        end else begin
            next_owner = req1_i.psel;
        end
    end

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            busy       <= 1'b0;
            owner      <= 1'b0;
            // CPU host goes first after reset
            last_owner <= 1'b1;
        end else begin
            if (busy) begin
                if (bus_rsp_i.pready) begin
                    busy <= 1'b0;
                end
            end else if (req0_i.psel || req1_i.psel) begin
                busy       <= 1'b1;
                owner      <= next_owner;
                last_owner <= next_owner;
            end
        end
    end

    assign owner_req = owner ? req1_i : req0_i;

    always_comb begin
        bus_req_o      = owner_req;
        // No owner, no select on the bus
        bus_req_o.psel = busy & owner_req.psel;
    end

    always_comb begin
        rsp0_o = '0;
        rsp1_o = '0;
        if (busy) begin
            if (owner) begin
                rsp1_o = bus_rsp_i;
            end else begin
                rsp0_o = bus_rsp_i;
            end
        end
    end

endmodule

// File: design/apb_reg_file.sv
//##########################################################################
// APB register file. Write registers are driven out to the logic around it,
// read registers are loaded from it when their valid bit is set. Index is
// taken from paddr[19:2]; pready is registered, so an access takes two
// cycles after setup. No error responses.
//##########################################################################

`include "regsub_macros.svh"

module apb_reg_file (
    input  logic                            clk_i,
    input  logic                            rstn_i,

    input  regsub_pkg::apb_req_t             apb_req_i,
    output regsub_pkg::apb_rsp_t             apb_rsp_o,

    input  regsub_pkg::rd_regs_t             rd_regs_i,
    input  logic [`REGSUB_RD_NUM-1:0]        rd_valid_i,

    output regsub_pkg::wr_regs_t             wr_regs_o,
    output logic [`REGSUB_WR_NUM-1:0]        wr_valid_o
);

    localparam int IDX_W = `REGSUB_IDX_MSB - `REGSUB_IDX_LSB + 1;

    logic [IDX_W-1:0] idx;
    logic             access;
    logic             write;
    logic             read;

    logic                      pready_q;
    logic [`REGSUB_DATA_W-1:0] prdata_q;

    regsub_pkg::wr_regs_t              wr_q;
    logic [`REGSUB_WR_NUM-1:0]         wr_valid_q;
    regsub_pkg::rd_regs_t              rd_in_q;
    logic [`REGSUB_RD_NUM-1:0]         rd_valid_q;
    regsub_pkg::rd_regs_t              rd_q;

    assign idx = apb_req_i.paddr[`REGSUB_IDX_MSB:`REGSUB_IDX_LSB];

    // Access counts once, the cycle before pready goes high
    assign access = apb_req_i.psel & apb_req_i.penable & ~pready_q;
    assign write  = access & apb_req_i.pwrite;
    assign read   = access & ~apb_req_i.pwrite;

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            wr_q       <= '0;
            wr_valid_q <= '0;
        end else begin
            wr_valid_q <= '0;
            if (write) begin
                for (int i = 0; i < `REGSUB_WR_NUM; i++) begin
                    if (idx == IDX_W'(i)) begin
                        wr_q[i]       <= apb_req_i.pwdata;
                        wr_valid_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // Output stage for the write side
    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            wr_regs_o  <= '0;
            wr_valid_o <= '0;
        end else begin
            wr_regs_o  <= wr_q;
            wr_valid_o <= wr_valid_q;
        end
    end

    // Input stage for the read side
    always_ff @(posedge clk_i) begin
        rd_in_q <= rd_regs_i;
    end

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            rd_valid_q <= '0;
            rd_q       <= regsub_pkg::RD_INIT;
        end else begin
            rd_valid_q <= rd_valid_i;
            for (int i = 0; i < `REGSUB_RD_NUM; i++) begin
                if (rd_valid_q[i]) begin
                    rd_q[i] <= rd_in_q[i];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (read) begin
            for (int i = 0; i < `REGSUB_RD_NUM; i++) begin
                if (idx == IDX_W'(i)) begin
                    prdata_q <= rd_q[i];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            pready_q <= 1'b0;
        end else begin
            pready_q <= access;
        end
    end

    always_comb begin
        apb_rsp_o.pready  = pready_q;
        apb_rsp_o.pslverr = 1'b0;
        apb_rsp_o.prdata  = prdata_q;
    end

endmodule

// File: design/event_counter.sv
//##########################################################################
// Event counter behind the register file. CTRL enables counting, clears
// and enables the interrupt; THRESH sets the level for the reached flag.
// Count and status go back as read registers with change pulses.
//##########################################################################

`include "regsub_macros.svh"

module event_counter (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    input  regsub_pkg::wr_regs_t        wr_regs_i,
    input  logic [`REGSUB_WR_NUM-1:0]   wr_valid_i,
    input  logic                       event_i,

    output regsub_pkg::rd_regs_t        rd_regs_o,
    output logic [`REGSUB_RD_NUM-1:0]   rd_valid_o,
    output logic                       irq_o
);

    logic [`REGSUB_DATA_W-1:0] ctrl;
    logic [`REGSUB_DATA_W-1:0] thresh;

    logic clear;
    logic count_en;
    logic event_q;
    logic reached;
    logic reached_nxt;
    logic count_chg;
    logic status_chg;

    logic [`REGSUB_DATA_W-1:0] count;

    assign ctrl     = wr_regs_i[`REG_CTRL];
    assign thresh   = wr_regs_i[`REG_THRESH];
    assign clear    = wr_valid_i[`REG_CTRL] & ctrl[`CTRL_CLR_BIT];
    assign count_en = event_q & ctrl[`CTRL_EN_BIT];

    // Sticky until cleared
    always_comb begin
        if (clear) begin
            reached_nxt = 1'b0;
        end else if ((thresh != '0) && (count >= thresh)) begin
            reached_nxt = 1'b1;
        end else begin
            reached_nxt = reached;
        end
    end

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            event_q    <= 1'b0;
            count      <= '0;
            count_chg  <= 1'b0;
            reached    <= 1'b0;
            status_chg <= 1'b0;
            irq_o      <= 1'b0;
        end else begin
            event_q <= event_i;
            if (clear) begin
                count     <= '0;
                count_chg <= (count != '0);
            end else if (count_en) begin
                count     <= count + `REGSUB_DATA_W'(1);
                count_chg <= 1'b1;
            end else begin
                count_chg <= 1'b0;
            end
            reached    <= reached_nxt;
            status_chg <= (reached_nxt != reached);
            irq_o      <= reached_nxt & ctrl[`CTRL_IRQ_EN_BIT];
        end
    end

    always_comb begin
        rd_regs_o              = '0;
        rd_regs_o[`REG_COUNT]  = count;
        rd_regs_o[`REG_STATUS] = `REGSUB_DATA_W'(reached);

        // ID slot never loads
        rd_valid_o              = '0;
        rd_valid_o[`REG_COUNT]  = count_chg;
        rd_valid_o[`REG_STATUS] = status_chg;
    end

endmodule

// File: design/regsub_macros.svh
//##########################################################################
// Shared constants for the peripheral register subsystem: bus widths,
// register counts, register indices, CTRL bit positions and the ID word.
// Include wherever one of these values is needed.
//##########################################################################

`ifndef REGSUB_MACROS_SVH
`define REGSUB_MACROS_SVH

`define REGSUB_DATA_W 32
`define REGSUB_ADDR_W 32
`define REGSUB_WR_NUM 2
`define REGSUB_RD_NUM 3

// Register index lives in paddr[19:2]
`define REGSUB_IDX_LSB 2
`define REGSUB_IDX_MSB 19

// Write side
`define REG_CTRL 0
`define REG_THRESH 1

// Read side
`define REG_COUNT 0
`define REG_STATUS 1
`define REG_ID 2

// CTRL bits
`define CTRL_EN_BIT 0
`define CTRL_CLR_BIT 1
`define CTRL_IRQ_EN_BIT 2

`define REGSUB_ID 32'h5245_4731

`endif

// File: design/regsub_pkg.sv
//##########################################################################
// Types for the register subsystem: APB request and response structs,
// the packed register arrays and the read register reset values.
// Referenced by scoped name from the RTL and the testbench.
//##########################################################################

`include "regsub_macros.svh"

package regsub_pkg;

    // Host to slave
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`REGSUB_ADDR_W-1:0] paddr;
        logic [`REGSUB_DATA_W-1:0] pwdata;
    } apb_req_t;

    // Slave to host
    typedef struct packed {
        logic                      pready;
        logic                      pslverr;
        logic [`REGSUB_DATA_W-1:0] prdata;
    } apb_rsp_t;

    typedef logic [`REGSUB_WR_NUM-1:0][`REGSUB_DATA_W-1:0] wr_regs_t;
    typedef logic [`REGSUB_RD_NUM-1:0][`REGSUB_DATA_W-1:0] rd_regs_t;

    function automatic rd_regs_t rd_init_calc();
        rd_regs_t init;
        init          = '0;
        init[`REG_ID] = `REGSUB_ID;
        return init;
    endfunction

    // Everything zero apart from the ID word
    localparam rd_regs_t RD_INIT = rd_init_calc();

endpackage

// File: design/regsub_top.sv
//##########################################################################
// Top of the peripheral register subsystem. CPU and debug APB hosts share
// the register file through the arbiter; the register file configures the
// event counter and reads back its count and status.
//##########################################################################

`include "regsub_macros.svh"

module regsub_top (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  regsub_pkg::apb_req_t cpu_req_i,
    input  regsub_pkg::apb_req_t dbg_req_i,
    output regsub_pkg::apb_rsp_t cpu_rsp_o,
    output regsub_pkg::apb_rsp_t dbg_rsp_o,

    input  logic                event_i,
    output logic                irq_o
);

    regsub_pkg::apb_req_t bus_req;
    regsub_pkg::apb_rsp_t bus_rsp;

    regsub_pkg::wr_regs_t             wr_regs;
    logic [`REGSUB_WR_NUM-1:0]        wr_valid;
    regsub_pkg::rd_regs_t             rd_regs;
    logic [`REGSUB_RD_NUM-1:0]        rd_valid;

    // CPU on port 0, debug on port 1
    apb_arbiter apb_arbiter_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .req0_i    (cpu_req_i),
        .req1_i    (dbg_req_i),
        .rsp0_o    (cpu_rsp_o),
        .rsp1_o    (dbg_rsp_o),
        .bus_req_o (bus_req),
        .bus_rsp_i (bus_rsp)
    );

    apb_reg_file apb_reg_file_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .apb_req_i  (bus_req),
        .apb_rsp_o  (bus_rsp),
        .rd_regs_i  (rd_regs),
        .rd_valid_i (rd_valid),
        .wr_regs_o  (wr_regs),
        .wr_valid_o (wr_valid)
    );

    event_counter event_counter_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_regs_i  (wr_regs),
        .wr_valid_i (wr_valid),
        .event_i    (event_i),
        .rd_regs_o  (rd_regs),
        .rd_valid_o (rd_valid),
        .irq_o      (irq_o)
    );

endmodule

// File: run.sh
#!/bin/sh
# Builds the register subsystem testbench with Verilator and runs it.
# The exit status is zero only when the run prints the pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f vlog.f --top-module regsub_tb -o regsub_sim

out=$(./obj_dir/regsub_sim)
echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
    exit 0
else
    exit 1
fi

// File: tb/regsub_assert.sv
//##########################################################################
// APB protocol checks on the arbiter, attached to apb_arbiter with bind.
// Covers response routing, select against grant, request hold and pslverr.
//##########################################################################

module regsub_assert (
    input logic                 clk_i,
    input logic                 rstn_i,
    input regsub_pkg::apb_req_t req0_i,
    input regsub_pkg::apb_req_t req1_i,
    input regsub_pkg::apb_rsp_t rsp0_i,
    input regsub_pkg::apb_rsp_t rsp1_i,
    input regsub_pkg::apb_req_t bus_req_i,
    input regsub_pkg::apb_rsp_t bus_rsp_i,
    input logic                 busy_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // A host sees pready only in its own access phase
    grant0_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp0_i.pready |-> (req0_i.psel && req0_i.penable))
        else $error("pready reached the CPU host outside its access phase");

    grant1_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp1_i.pready |-> (req1_i.psel && req1_i.penable))
        else $error("pready reached the debug host outside its access phase");

    psel_grant_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_req_i.psel == busy_i)
        else $error("Bus psel does not match the grant");

    // Access phase must hold until the slave answers
    hold_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (bus_req_i.psel && bus_req_i.penable && !bus_rsp_i.pready)
        |=> $stable(bus_req_i))
        else $error("Granted request changed before pready");

    slverr_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !bus_rsp_i.pslverr)
        else $error("pslverr went high");

endmodule

// File: tb/regsub_tb.sv
//##########################################################################
// Testbench for the register subsystem. A table of APB transfers and event
// bursts is applied in order from the CPU and debug hosts; read data and
// irq_o are compared with the expected columns after each entry.
//##########################################################################

`include "regsub_macros.svh"

module regsub_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS      = 40;
    localparam int N_ENTRIES   = 17;
    localparam int WATCHDOG_NS = N_ENTRIES * 40 * CLK_NS;

    localparam logic [31:0] EN  = 32'h1 << `CTRL_EN_BIT;
    localparam logic [31:0] CLR = 32'h1 << `CTRL_CLR_BIT;
    localparam logic [31:0] IRQ = 32'h1 << `CTRL_IRQ_EN_BIT;

    // Host 0 is CPU, 1 is debug, 2 runs the CPU transfer beside a debug ID read
    typedef struct packed {
        int          host;
        bit          wr;
        int          idx;
        logic [31:0] wdata;
        int          events;
        logic [31:0] exp;
        bit          irq;
    } entry_t;

    localparam entry_t TABLE [N_ENTRIES] = '{
        '{0, 1'b0, `REG_COUNT,  32'h0,           0, 32'h0,      1'b0},
        '{1, 1'b0, `REG_STATUS, 32'h0,           0, 32'h0,      1'b0},
        '{0, 1'b0, `REG_ID,     32'h0,           0, `REGSUB_ID, 1'b0},
        '{0, 1'b1, `REG_THRESH, 32'h5,           0, 32'h0,      1'b0},
        '{0, 1'b1, `REG_CTRL,   EN,              0, 32'h0,      1'b0},
        '{0, 1'b0, `REG_COUNT,  32'h0,           3, 32'h3,      1'b0},
        '{1, 1'b0, `REG_STATUS, 32'h0,           0, 32'h0,      1'b0},
        '{0, 1'b0, `REG_STATUS, 32'h0,           2, 32'h1,      1'b0},
        '{1, 1'b1, `REG_CTRL,   EN | IRQ,        0, 32'h0,      1'b1},
        '{0, 1'b1, `REG_CTRL,   EN | CLR | IRQ,  0, 32'h0,      1'b0},
        '{1, 1'b0, `REG_COUNT,  32'h0,           0, 32'h0,      1'b0},
        '{0, 1'b0, `REG_STATUS, 32'h0,           0, 32'h0,      1'b0},
        '{2, 1'b1, `REG_THRESH, 32'h2,           0, `REGSUB_ID, 1'b0},
        '{0, 1'b0, `REG_STATUS, 32'h0,           2, 32'h1,      1'b1},
        '{1, 1'b0, `REG_COUNT,  32'h0,           0, 32'h2,      1'b1},
        '{0, 1'b1, `REG_CTRL,   IRQ,             0, 32'h0,      1'b1},
        '{0, 1'b0, `REG_COUNT,  32'h0,           3, 32'h2,      1'b1}
    };

    string names [N_ENTRIES] = '{
        "reset_count", "reset_status", "reset_id", "thresh_5", "ctrl_enable",
        "count_3", "status_below", "status_reached", "irq_enable", "clear",
        "clear_count", "clear_status", "concurrent", "status_thresh_2",
        "count_2", "disable", "count_held"
    };

    logic                 clk;
    logic                 rstn;
    logic                 evt;
    logic                 irq;
    regsub_pkg::apb_req_t cpu_req;
    regsub_pkg::apb_req_t dbg_req;
    regsub_pkg::apb_rsp_t cpu_rsp;
    regsub_pkg::apb_rsp_t dbg_rsp;
    int                   errors = 0;

    tb_clkgen tb_clkgen_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    regsub_top regsub_top_i (
        .clk_i     (clk),
        .rstn_i    (rstn),
        .cpu_req_i (cpu_req),
        .dbg_req_i (dbg_req),
        .cpu_rsp_o (cpu_rsp),
        .dbg_rsp_o (dbg_rsp),
        .event_i   (evt),
        .irq_o     (irq)
    );

    bind apb_arbiter regsub_assert regsub_assert_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .req0_i    (req0_i),
        .req1_i    (req1_i),
        .rsp0_i    (rsp0_o),
        .rsp1_i    (rsp1_o),
        .bus_req_i (bus_req_o),
        .bus_rsp_i (bus_rsp_i),
        .busy_i    (busy)
    );

    task automatic set_req(input int host, input regsub_pkg::apb_req_t req);
        if (host == 0) begin
            cpu_req = req;
        end else begin
            dbg_req = req;
        end
    endtask

    // Setup, access, wait for pready, hold through that edge, then release
    task automatic apb_xfer(input string name, input int host, input bit wr,
                            input int idx, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        regsub_pkg::apb_req_t req;
        regsub_pkg::apb_rsp_t rsp;
        req         = '0;
        req.psel    = 1'b1;
        req.pwrite  = wr;
        req.paddr   = 32'(idx * 4);
        req.pwdata  = wdata;
        set_req(host, req);
        @(negedge clk);
        req.penable = 1'b1;
        set_req(host, req);
        do begin
            @(negedge clk);
            rsp = (host == 0) ? cpu_rsp : dbg_rsp;
        end while (!rsp.pready);
        rdata = rsp.prdata;
        check_value({name, "/pslverr"}, 32'h0, 32'(rsp.pslverr));
        @(negedge clk);
        set_req(host, '0);
    endtask

    task automatic drive_events(input int n);
        int gap;
        for (int k = 0; k < n; k++) begin
            evt = 1'b1;
            @(negedge clk);
            evt = 1'b0;
            gap = int'($urandom % 3) + 1;
            repeat (gap) @(negedge clk);
        end
        // Read side lags the count by a few registers
        repeat (4) @(negedge clk);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic run_entry(input int i);
        entry_t      e;
        logic [31:0] rdata;
        logic [31:0] id_data;
        e = TABLE[i];
        drive_events(e.events);
        if (e.host == 2) begin
            fork
                apb_xfer(names[i], 0, e.wr, e.idx, e.wdata, rdata);
                apb_xfer(names[i], 1, 1'b0, `REG_ID, 32'h0, id_data);
            join
            check_value(names[i], e.exp, id_data);
        end else begin
            apb_xfer(names[i], e.host, e.wr, e.idx, e.wdata, rdata);
            if (!e.wr) begin
                check_value(names[i], e.exp, rdata);
            end
        end
        // irq_o trails a CTRL write by two edges
        repeat (3) @(negedge clk);
        check_value({names[i], "/irq"}, 32'(e.irq), 32'(irq));
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired before the table finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        cpu_req = '0;
        dbg_req = '0;
        evt     = 1'b0;
        void'($urandom(32'h5dba));
        @(posedge rstn);
        @(negedge clk);
        for (int i = 0; i < N_ENTRIES; i++) begin
            run_entry(i);
        end
        $display("Table done: %0d entries, %0d errors", N_ENTRIES, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb/tb_clkgen.sv
//##########################################################################
// Clock and reset source for the testbench: 40 ns clock, active-low reset
// held for four cycles and released on a falling edge.
//##########################################################################

module tb_clkgen (
    output logic clk_o,
    output logic rstn_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

// File: vlog.f
+incdir+design
design/regsub_pkg.sv
design/apb_arbiter.sv
design/apb_reg_file.sv
design/event_counter.sv
design/regsub_top.sv
tb/tb_clkgen.sv
tb/regsub_assert.sv
tb/regsub_tb.sv
